//--- rtl/fp_pkg.sv
// Single-precision format used by the vector multiply unit.
// A zero exponent means zero. NaN and infinity are passed through as
// ordinary numbers and get no special handling anywhere in the datapath.
// The integer view of an operand is a plain 32-bit two's complement word.
`default_nettype none

package fp_pkg;

	// Format widths are tied to the 32-bit word
	localparam int EXP_WIDTH = 8;
	localparam int SIG_WIDTH = 23;
	localparam int EXP_BIAS = 127;

	// IEEE bit order with the sign in bit 31
	typedef struct packed {
		logic sign;
		logic [EXP_WIDTH-1:0] exponent;
		logic [SIG_WIDTH-1:0] fraction;
	} fp_fields_t;

	// One operand word
	// Float view for FMUL and results, integer view for the ITOF source
	typedef union packed {
		fp_fields_t f;
		logic signed [31:0] i;
	} operand_t;

endpackage

`default_nettype wire

//--- rtl/mul_op_pkg.sv
// Operation codes and pipeline stage records of the multiply unit.
// Stage exponents are biased but carry two extra bits, so values
// below 1 or above 254 survive until the normalize step drops them.
`default_nettype none

package mul_op_pkg;

	// Only two encodings are used, the others decode as FMUL
	typedef enum logic [1:0] {
		OP_FMUL = 2'd0,
		OP_ITOF = 2'd1
	} mul_op_t;

	// Request fields that do not scale with the lane count
	typedef struct packed {
		mul_op_t op;
	} mul_req_t;

	// Decoded once in the issue slot and shared by every lane
	typedef struct packed {
		logic is_itof;
	} lane_ctl_t;

	// Extra range bit plus sign bit on top of the format exponent
	localparam int STAGE_EXP_WIDTH = fp_pkg::EXP_WIDTH + 2;
	// Hidden bit plus stored fraction
	localparam int SIG_A_WIDTH = fp_pkg::SIG_WIDTH + 1;
	// Wide enough for the magnitude of any 32-bit integer
	localparam int MAG_B_WIDTH = 32;
	localparam int PROD_WIDTH = SIG_A_WIDTH + MAG_B_WIDTH;

	typedef struct packed {
		logic sign;
		logic signed [STAGE_EXP_WIDTH-1:0] exponent;
		logic zero;
		logic [SIG_A_WIDTH-1:0] sig_a;
		logic [MAG_B_WIDTH-1:0] mag_b;
	} prep_stage_t;

	typedef struct packed {
		logic sign;
		logic signed [STAGE_EXP_WIDTH-1:0] exponent;
		logic zero;
		logic [PROD_WIDTH-1:0] product;
	} prod_stage_t;

endpackage

`default_nettype wire

//--- rtl/fp_mul_issue.sv
// Input slot of the multiply pipeline.
// The slot refills while the pipeline is stalled if it is empty, so
// in_ready_o drops only when the slot is full and advance_i is low.
// The requester must hold in_valid_i and the request until accepted.
`timescale 1ns/1ps
`default_nettype none

module fp_mul_issue #(
	parameter int LANES = 4
) (
	input wire clk,
	input wire rst_i,
	input wire in_valid_i,
	output logic in_ready_o,
	input wire mul_op_pkg::mul_op_t in_op_i,
	input wire fp_pkg::operand_t [LANES-1:0] in_a_i,
	input wire fp_pkg::operand_t [LANES-1:0] in_b_i,
	input wire advance_i,
	output logic issue_valid_o,
	output mul_op_pkg::lane_ctl_t issue_ctl_o,
	output fp_pkg::operand_t [LANES-1:0] issue_a_o,
	output fp_pkg::operand_t [LANES-1:0] issue_b_o
);

	logic slot_valid_q;
	mul_op_pkg::mul_req_t slot_q;
	logic accept;

	// Slot can take a request when empty or when it drains this cycle
	assign in_ready_o = !slot_valid_q || advance_i;
	assign accept = in_valid_i && in_ready_o;

	always_ff @(posedge clk)
	begin
		if (rst_i)
			slot_valid_q <= 1'b0;
		else if (in_ready_o)
			slot_valid_q <= in_valid_i;
	end

	// Payload only changes on an accepted request
	always_ff @(posedge clk)
	begin
		if (accept)
		begin
			slot_q.op <= in_op_i;
			issue_a_o <= in_a_i;
			issue_b_o <= in_b_i;
		end
	end

	assign issue_valid_o = slot_valid_q;

	// One decode for all lanes
	always_comb
	begin
		issue_ctl_o.is_itof = (slot_q.op == mul_op_pkg::OP_ITOF);
	end

	// Requester side of the handshake
	a_req_held: assert property (@(posedge clk) disable iff (rst_i)
		in_valid_i && !in_ready_o |=> in_valid_i && $stable(in_op_i)
			&& $stable(in_a_i) && $stable(in_b_i))
		else $error("request changed or dropped while waiting for in_ready_o");

endmodule

`default_nettype wire

//--- rtl/fp_mul_operand_prep.sv
// First lane stage of the multiplier.
// Denormal inputs count as zero. ITOF is a multiply by 1.0 where B is an
// unnormalized float with exponent 127 + 23 and the integer magnitude as
// its significand. The exponent kept here is the biased result exponent
// for a product whose hidden one sits at bit 46.
`timescale 1ns/1ps
`default_nettype none

module fp_mul_operand_prep (
	input wire clk,
	input wire rst_i,
	input wire advance_i,
	input wire mul_op_pkg::lane_ctl_t ctl_i,
	input wire fp_pkg::operand_t a_i,
	input wire fp_pkg::operand_t b_i,
	output mul_op_pkg::prep_stage_t prep_o
);

	localparam int EW = mul_op_pkg::STAGE_EXP_WIDTH;

	logic sign_a;
	logic sign_b;
	logic [fp_pkg::EXP_WIDTH-1:0] exp_a;
	logic [fp_pkg::EXP_WIDTH-1:0] exp_b;
	logic signed [EW-1:0] unbiased_a;
	logic signed [EW-1:0] unbiased_b;
	logic [mul_op_pkg::SIG_A_WIDTH-1:0] sig_a;
	logic [mul_op_pkg::MAG_B_WIDTH-1:0] mag_b;
	logic zero;
	mul_op_pkg::prep_stage_t prep_d;

	// Operand A
	always_comb
	begin
		if (ctl_i.is_itof)
		begin
			// Constant 1.0
			sign_a = 1'b0;
			exp_a = fp_pkg::EXP_WIDTH'(fp_pkg::EXP_BIAS);
			sig_a = {1'b1, {fp_pkg::SIG_WIDTH{1'b0}}};
		end
		else
		begin
			sign_a = a_i.f.sign;
			exp_a = a_i.f.exponent;
			sig_a = {a_i.f.exponent != '0, a_i.f.fraction};
		end
	end

	// Operand B, decoded by the op
	always_comb
	begin
		if (ctl_i.is_itof)
		begin
			sign_b = b_i.i[31];
			exp_b = fp_pkg::EXP_WIDTH'(fp_pkg::EXP_BIAS + fp_pkg::SIG_WIDTH);
			// Magnitude of -2^31 still fits as an unsigned word
			mag_b = b_i.i[31] ? 32'(-b_i.i) : 32'(b_i.i);
		end
		else
		begin
			sign_b = b_i.f.sign;
			exp_b = b_i.f.exponent;
			mag_b = mul_op_pkg::MAG_B_WIDTH'({b_i.f.exponent != '0, b_i.f.fraction});
		end
	end

	// Zero result detection
	always_comb
	begin
		if (ctl_i.is_itof)
			zero = (b_i.i == 0);
		else
			zero = (a_i.f.exponent == '0) || (b_i.f.exponent == '0);
	end

	// Unbias, add with room for overflow, then rebias once
	assign unbiased_a = EW'(exp_a) - EW'(fp_pkg::EXP_BIAS);
	assign unbiased_b = EW'(exp_b) - EW'(fp_pkg::EXP_BIAS);

	always_comb
	begin
		prep_d.sign = sign_a ^ sign_b;
		prep_d.exponent = unbiased_a + unbiased_b + EW'(fp_pkg::EXP_BIAS);
		prep_d.zero = zero;
		prep_d.sig_a = sig_a;
		prep_d.mag_b = mag_b;
	end

	// Only the zero flag needs a known value after reset
	always_ff @(posedge clk)
	begin
		if (rst_i)
			prep_o.zero <= 1'b1;
		else if (advance_i)
			prep_o <= prep_d;
	end

endmodule

`default_nettype wire

//--- rtl/fp_mul_normalize.sv
// Final lane step, purely combinational.
// The fraction is truncated toward zero. A set zero flag or a final
// exponent outside 1 to 254 gives a zero with the product sign.
`timescale 1ns/1ps
`default_nettype none

module fp_mul_normalize (
	input wire mul_op_pkg::prod_stage_t prod_i,
	output fp_pkg::operand_t result_o
);

	localparam int PW = mul_op_pkg::PROD_WIDTH;
	localparam int EW = mul_op_pkg::STAGE_EXP_WIDTH;
	localparam int LW = $clog2(PW);
	// Hidden one position when both significands are normal
	localparam int REF_BIT = 2 * fp_pkg::SIG_WIDTH;
	localparam int EXP_MAX = (2 ** fp_pkg::EXP_WIDTH) - 2;

	logic [LW-1:0] lead;
	logic [PW-1:0] shifted;
	logic signed [EW-1:0] res_exp;
	logic in_range;

	// Leading one search, highest set bit wins
	always_comb
	begin
		lead = '0;
		for (int i = 0; i < PW; i++)
		begin
			if (prod_i.product[i])
				lead = LW'(i);
		end
	end

	// Leading one moves to the top bit, fraction follows right below it
	assign shifted = prod_i.product << (PW - 1 - lead);

	// Exponent moves by the distance of the leading one from bit 46
	assign res_exp = prod_i.exponent + EW'(lead) - EW'(REF_BIT);
	assign in_range = (res_exp > 0) && (res_exp <= EXP_MAX);

	always_comb
	begin
		result_o.f.sign = prod_i.sign;
		if (prod_i.zero || !in_range)
		begin
			result_o.f.exponent = '0;
			result_o.f.fraction = '0;
		end
		else
		begin
			result_o.f.exponent = res_exp[fp_pkg::EXP_WIDTH-1:0];
			// Bits below the fraction are dropped
			result_o.f.fraction = shifted[PW-2 -: fp_pkg::SIG_WIDTH];
		end
	end

endmodule

`default_nettype wire

//--- rtl/fp_mul_lane.sv
// One lane of the vector multiplier.
// Two registers deep: the prep register and the product register.
// The normalized result is combinational from the product register.
`timescale 1ns/1ps
`default_nettype none

module fp_mul_lane (
	input wire clk,
	input wire rst_i,
	input wire advance_i,
	input wire mul_op_pkg::lane_ctl_t ctl_i,
	input wire fp_pkg::operand_t a_i,
	input wire fp_pkg::operand_t b_i,
	output fp_pkg::operand_t result_o
);

	mul_op_pkg::prep_stage_t prep;
	mul_op_pkg::prod_stage_t prod_q;

	fp_mul_operand_prep prep_inst (
		.clk(clk),
		.rst_i(rst_i),
		.advance_i(advance_i),
		.ctl_i(ctl_i),
		.a_i(a_i),
		.b_i(b_i),
		.prep_o(prep)
	);

	// Product register, 24 x 32 significand multiply
	always_ff @(posedge clk)
	begin
		if (rst_i)
			prod_q.zero <= 1'b1;
		else if (advance_i)
		begin
			prod_q.sign <= prep.sign;
			prod_q.exponent <= prep.exponent;
			prod_q.zero <= prep.zero;
			prod_q.product <= prep.sig_a * prep.mag_b;
		end
	end

	fp_mul_normalize norm_inst (
		.prod_i(prod_q),
		.result_o(result_o)
	);

	// FMUL lands at bit 46 or 47, ITOF anywhere from bit 23 to bit 54
	a_prod_span: assert property (@(posedge clk) disable iff (rst_i)
		!prod_q.zero |-> !prod_q.product[mul_op_pkg::PROD_WIDTH-1]
			&& (|prod_q.product[mul_op_pkg::PROD_WIDTH-2:fp_pkg::SIG_WIDTH]))
		else $error("product leading one outside expected span");

endmodule

`default_nettype wire

//--- rtl/fp_mul_collect.sv
// Valid tracking and output register of the multiply pipeline.
// Every register in the unit moves on advance_o, which is high while the
// output register is empty or being consumed. No bubble squeezing.
`timescale 1ns/1ps
`default_nettype none

module fp_mul_collect #(
	parameter int LANES = 4
) (
	input wire clk,
	input wire rst_i,
	input wire issue_valid_i,
	input wire fp_pkg::operand_t [LANES-1:0] lane_result_i,
	output logic advance_o,
	output logic out_valid_o,
	input wire out_ready_i,
	output fp_pkg::operand_t [LANES-1:0] out_result_o
);

	logic prep_valid_q;
	logic prod_valid_q;

	assign advance_o = !out_valid_o || out_ready_i;

	// Valid chain follows the issue slot through prep and product
	always_ff @(posedge clk)
	begin
		if (rst_i)
		begin
			prep_valid_q <= 1'b0;
			prod_valid_q <= 1'b0;
			out_valid_o <= 1'b0;
		end
		else if (advance_o)
		begin
			prep_valid_q <= issue_valid_i;
			prod_valid_q <= prep_valid_q;
			out_valid_o <= prod_valid_q;
		end
	end

	// Captures only real results
	always_ff @(posedge clk)
	begin
		if (advance_o && prod_valid_q)
			out_result_o <= lane_result_i;
	end

	a_out_hold: assert property (@(posedge clk) disable iff (rst_i)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_result_o))
		else $error("result changed while stalled");

endmodule

`default_nettype wire

//--- rtl/fp_mul_top.sv
// Vector floating-point multiply unit, FMUL and ITOF over LANES lanes.
// Four cycles from acceptance to out_valid_o with no back-pressure.
// One request per cycle, results in request order.
`timescale 1ns/1ps
`default_nettype none

module fp_mul_top #(
	parameter int LANES = 4
) (
	input wire clk,
	input wire rst_i,
	input wire in_valid_i,
	output logic in_ready_o,
	input wire mul_op_pkg::mul_op_t in_op_i,
	input wire fp_pkg::operand_t [LANES-1:0] in_a_i,
	input wire fp_pkg::operand_t [LANES-1:0] in_b_i,
	output logic out_valid_o,
	input wire out_ready_i,
	output fp_pkg::operand_t [LANES-1:0] out_result_o
);

	logic advance;
	logic issue_valid;
	mul_op_pkg::lane_ctl_t issue_ctl;
	fp_pkg::operand_t [LANES-1:0] issue_a;
	fp_pkg::operand_t [LANES-1:0] issue_b;
	fp_pkg::operand_t [LANES-1:0] lane_result;

	fp_mul_issue #(
		.LANES(LANES)
	) issue_inst (
		.clk(clk),
		.rst_i(rst_i),
		.in_valid_i(in_valid_i),
		.in_ready_o(in_ready_o),
		.in_op_i(in_op_i),
		.in_a_i(in_a_i),
		.in_b_i(in_b_i),
		.advance_i(advance),
		.issue_valid_o(issue_valid),
		.issue_ctl_o(issue_ctl),
		.issue_a_o(issue_a),
		.issue_b_o(issue_b)
	);

	// Lanes share control and advance
	for (genvar g = 0; g < LANES; g++)
	begin : g_lane
		fp_mul_lane lane_inst (
			.clk(clk),
			.rst_i(rst_i),
			.advance_i(advance),
			.ctl_i(issue_ctl),
			.a_i(issue_a[g]),
			.b_i(issue_b[g]),
			.result_o(lane_result[g])
		);
	end

	fp_mul_collect #(
		.LANES(LANES)
	) collect_inst (
		.clk(clk),
		.rst_i(rst_i),
		.issue_valid_i(issue_valid),
		.lane_result_i(lane_result),
		.advance_o(advance),
		.out_valid_o(out_valid_o),
		.out_ready_i(out_ready_i),
		.out_result_o(out_result_o)
	);

endmodule

`default_nettype wire

//--- bench/fp_mul_model.svh
// Reference model for the vector multiply unit.
// Denormal inputs count as zero and fractions truncate toward zero.
// Any result exponent outside 1 to 254 gives a zero with the product sign.
// NaN and infinity are plain numbers here as well.
`ifndef FP_MUL_MODEL_SVH
`define FP_MUL_MODEL_SVH

// Single-precision product under the unit's simplified rules
function automatic fp_pkg::operand_t mul_float_trunc(fp_pkg::operand_t a, fp_pkg::operand_t b);
	fp_pkg::operand_t res;
	logic [47:0] prod;
	int exp_sum;
	res = '0;
	res.f.sign = a.f.sign ^ b.f.sign;
	prod = 48'({1'b1, a.f.fraction}) * 48'({1'b1, b.f.fraction});
	exp_sum = int'(a.f.exponent) + int'(b.f.exponent) - fp_pkg::EXP_BIAS;
	// Product of two values in [1,2) may reach [2,4)
	if (prod[47])
	begin
		exp_sum++;
		prod = prod >> 1;
	end
	if (a.f.exponent == 0 || b.f.exponent == 0 || exp_sum < 1 || exp_sum > 254)
		return res;
	res.f.exponent = exp_sum[7:0];
	res.f.fraction = prod[45:23];
	return res;
endfunction

// Signed integer to float, low bits beyond the fraction are dropped
function automatic fp_pkg::operand_t int_to_float_trunc(logic signed [31:0] value);
	fp_pkg::operand_t res;
	logic [31:0] mag;
	int msb;
	res = '0;
	if (value == 0)
		return res;
	res.f.sign = value < 0;
	// -2^31 keeps its bit pattern as an unsigned magnitude
	mag = (value < 0) ? -value : value;
	msb = 0;
	for (int i = 0; i < 32; i++)
	begin
		if (mag[i])
			msb = i;
	end
	res.f.exponent = 8'(fp_pkg::EXP_BIAS + msb);
	if (msb >= fp_pkg::SIG_WIDTH)
		res.f.fraction = 23'(mag >> (msb - fp_pkg::SIG_WIDTH));
	else
		res.f.fraction = 23'(mag << (fp_pkg::SIG_WIDTH - msb));
	return res;
endfunction

`endif

//--- bench/tb_fp_mul.sv
// Testbench for the vector multiply unit with four lanes.
// Every accepted request queues its model results, and concurrent
// assertions check data, order, latency and stall behavior.
`timescale 1ns/1ps
`default_nettype none

module tb_fp_mul;

	localparam int LANES = 4;
	localparam int CLK_PERIOD = 20;
	localparam int NUM_RANDOM = 40;
	localparam int NUM_BURST = 200;
	// Eight cycles per request at worst, plus reset and drain
	localparam int TIMEOUT_CYCLES = 8 * (2 * NUM_RANDOM + NUM_BURST + 10) + 200;

	typedef fp_pkg::operand_t [LANES-1:0] vec_t;

	logic clk;
	logic rst_i;
	logic in_valid_i;
	logic in_ready_o;
	mul_op_pkg::mul_op_t in_op_i;
	vec_t in_a_i;
	vec_t in_b_i;
	logic out_valid_o;
	logic out_ready_i;
	vec_t out_result_o;

	// Scoreboard state
	vec_t expected_q[$];
	vec_t head_word;
	logic head_present;
	int fail_count;
	int accepted;
	int consumed;
	int fails;
	// Back-pressure pattern, replayed by cycle count
	logic random_ready;
	bit ready_pattern[256];
	int cycle = 0;

	`include "fp_mul_model.svh"

	fp_mul_top #(
		.LANES(LANES)
	) fp_mul_top_inst (
		.clk(clk),
		.rst_i(rst_i),
		.in_valid_i(in_valid_i),
		.in_ready_o(in_ready_o),
		.in_op_i(in_op_i),
		.in_a_i(in_a_i),
		.in_b_i(in_b_i),
		.out_valid_o(out_valid_o),
		.out_ready_i(out_ready_i),
		.out_result_o(out_result_o)
	);

	initial
	begin
		clk = 1'b0;
		forever
			#(CLK_PERIOD / 2) clk = ~clk;
	end

	always @(posedge clk)
	begin
		cycle <= cycle + 1;
		out_ready_i <= random_ready ? ready_pattern[cycle % 256] : 1'b1;
	end

	task automatic record_failure(input string msg);
		fail_count++;
		$display("FAILED at %0t: %s", $time, msg);
	endtask

	// Pop on consume, push model results on accept
	always @(posedge clk)
	begin : scoreboard
		vec_t expect_vec;
		if (!rst_i)
		begin
			if (out_valid_o && out_ready_i)
			begin
				consumed++;
				if (expected_q.size() > 0)
					void'(expected_q.pop_front());
			end
			if (in_valid_i && in_ready_o)
			begin
				for (int l = 0; l < LANES; l++)
				begin
					if (in_op_i == mul_op_pkg::OP_ITOF)
						expect_vec[l] = int_to_float_trunc(in_b_i[l].i);
					else
						expect_vec[l] = mul_float_trunc(in_a_i[l], in_b_i[l]);
				end
				expected_q.push_back(expect_vec);
				accepted++;
			end
			head_present <= expected_q.size() > 0;
			head_word <= (expected_q.size() > 0) ? expected_q[0] : '0;
		end
	end

	a_result: assert property (@(posedge clk) disable iff (rst_i)
		out_valid_o && out_ready_i |-> head_present && out_result_o == head_word)
		else record_failure($sformatf("result %h, expected %h",
			$sampled(out_result_o), $sampled(head_word)));

	// Four edges from acceptance when out_ready_i stays high
	a_latency: assert property (@(posedge clk) disable iff (rst_i)
		in_valid_i && in_ready_o ##1 out_ready_i ##1 out_ready_i ##1 out_ready_i
			|=> out_valid_o)
		else record_failure("no result four edges after acceptance");

	a_stall_hold: assert property (@(posedge clk) disable iff (rst_i)
		out_valid_o && !out_ready_i |=> out_valid_o && $stable(out_result_o))
		else record_failure("result changed or dropped while stalled");

	// Only a full issue slot behind a stalled output may refuse input
	a_ready_low: assert property (@(posedge clk) disable iff (rst_i)
		!in_ready_o |-> fp_mul_top_inst.issue_valid && out_valid_o && !out_ready_i)
		else record_failure("in_ready_o low without a full slot and a stall");

	a_reset_state: assert property (@(posedge clk) disable iff (rst_i)
		$fell(rst_i) |-> !out_valid_o && in_ready_o)
		else record_failure("wrong handshake state after reset");

	// Holds the request until the edge that accepts it
	// in_ready_o is settled at the falling edge before that rising edge
	task automatic issue_request(input mul_op_pkg::mul_op_t op, input vec_t a, input vec_t b);
		in_valid_i <= 1'b1;
		in_op_i <= op;
		in_a_i <= a;
		in_b_i <= b;
		@(negedge clk);
		while (!in_ready_o)
			@(negedge clk);
		@(posedge clk);
		in_valid_i <= 1'b0;
	endtask

	function automatic fp_pkg::operand_t rand_normal();
		fp_pkg::operand_t w;
		w.f.sign = 1'($urandom_range(1, 0));
		// Keeps most products inside the exponent range
		w.f.exponent = 8'($urandom_range(160, 95));
		w.f.fraction = 23'($urandom());
		return w;
	endfunction

	// Small values, full-range words, zero and magnitudes above 2^24
	function automatic logic signed [31:0] rand_int();
		logic signed [31:0] v;
		case ($urandom_range(3, 0))
			0: v = $urandom_range(2000, 0) - 1000;
			1: v = $urandom();
			2: v = 0;
			default:
			begin
				v = $urandom_range(32'h7FFF_FFFF, 32'h0100_0001);
				if ($urandom_range(1, 0) == 1)
					v = -v;
			end
		endcase
		return v;
	endfunction

	task automatic send_random(input mul_op_pkg::mul_op_t op);
		vec_t a;
		vec_t b;
		for (int l = 0; l < LANES; l++)
		begin
			a[l] = rand_normal();
			if (op == mul_op_pkg::OP_ITOF)
				b[l].i = rand_int();
			else
				b[l] = rand_normal();
		end
		issue_request(op, a, b);
	endtask

	// Drain, let the last assertions fire, then report
	task automatic finish_test(input string name, input int fails_before);
		@(negedge clk);
		while (expected_q.size() > 0)
			@(negedge clk);
		repeat (2) @(posedge clk);
		$display("Test %s finished with %0d errors", name, fail_count - fails_before);
	endtask

	initial
	begin
		void'($urandom(17));
		rst_i = 1'b1;
		in_valid_i = 1'b0;
		in_op_i = mul_op_pkg::OP_FMUL;
		in_a_i = '0;
		in_b_i = '0;
		out_ready_i = 1'b1;
		random_ready = 1'b0;
		head_present = 1'b0;
		head_word = '0;
		fail_count = 0;
		accepted = 0;
		consumed = 0;
		repeat (8) @(posedge clk);
		rst_i <= 1'b0;
		fails = fail_count;
		finish_test("reset", fails);

		// Exact products, spaced out so each latency is seen alone
		fails = fail_count;
		issue_request(mul_op_pkg::OP_FMUL,
			{32'hBF00_0000, 32'h3F80_0000, 32'h4040_0000, 32'h3FC0_0000},
			{32'hC100_0000, 32'h40E0_0000, 32'h3E80_0000, 32'hC000_0000});
		repeat (6) @(posedge clk);
		issue_request(mul_op_pkg::OP_FMUL,
			{32'h4000_0000, 32'hC040_0000, 32'h3F00_0000, 32'h3FC0_0000},
			{32'h4000_0000, 32'h3E80_0000, 32'h4080_0000, 32'h3FC0_0000});
		finish_test("directed FMUL", fails);

		fails = fail_count;
		for (int n = 0; n < NUM_RANDOM; n++)
			send_random(mul_op_pkg::OP_FMUL);
		finish_test("random FMUL", fails);

		// Extremes first, then random integers
		fails = fail_count;
		issue_request(mul_op_pkg::OP_ITOF, '0,
			{32'h8000_0000, 32'h7FFF_FFFF, 32'h0100_0001, 32'hFFFF_FFFF});
		for (int n = 0; n < NUM_RANDOM; n++)
			send_random(mul_op_pkg::OP_ITOF);
		finish_test("ITOF", fails);

		// Denormal, zero, underflow, overflow and both range edges
		fails = fail_count;
		issue_request(mul_op_pkg::OP_FMUL,
			{32'h6400_0000, 32'h0A00_0000, 32'h0000_0000, 32'h0001_2345},
			{32'h6400_0000, 32'h0A00_0000, 32'hC040_0000, 32'h3F80_0000});
		issue_request(mul_op_pkg::OP_FMUL,
			{32'h007F_FFFF, 32'h5F00_0000, 32'h5F7F_FFFF, 32'h2000_0000},
			{32'h7F00_0000, 32'h5F80_0000, 32'h5FFF_FFFF, 32'h2000_0000});
		finish_test("signed zero", fails);

		// Bursts against a random output stall pattern
		fails = fail_count;
		for (int i = 0; i < 256; i++)
			ready_pattern[i] = ($urandom_range(1, 0) == 1);
		random_ready <= 1'b1;
		for (int n = 0; n < NUM_BURST; n++)
		begin
			send_random($urandom_range(1, 0) ? mul_op_pkg::OP_ITOF : mul_op_pkg::OP_FMUL);
			if ($urandom_range(3, 0) == 0)
				repeat ($urandom_range(3, 1)) @(posedge clk);
		end
		random_ready <= 1'b0;
		finish_test("back-pressure", fails);

		assert (expected_q.size() == 0 && accepted == consumed)
		else
			record_failure($sformatf("%0d requests accepted but %0d results consumed",
				accepted, consumed));
		$display("Requests %0d, results %0d, errors %0d", accepted, consumed, fail_count);
		if (fail_count == 0)
			$display("Simulation completed successfully");
		else
			$display("Simulation failed");
		$finish;
	end

	initial
	begin
		#(TIMEOUT_CYCLES * CLK_PERIOD);
		$display("Timeout: the tests did not finish within %0d cycles", TIMEOUT_CYCLES);
		$display("Simulation failed");
		$finish;
	end

endmodule

`default_nettype wire

//--- list.f
+incdir+bench
rtl/fp_pkg.sv
rtl/mul_op_pkg.sv
rtl/fp_mul_issue.sv
rtl/fp_mul_operand_prep.sv
rtl/fp_mul_normalize.sv
rtl/fp_mul_lane.sv
rtl/fp_mul_collect.sv
rtl/fp_mul_top.sv
bench/tb_fp_mul.sv
